// ==== compile.f ====
source/isaPkg.sv
source/memPkg.sv
source/controlUnit.sv
source/registerFile.sv
source/alu.sv
source/memArbiter.sv
source/unifiedMemory.sv
source/cpuCore.sv
source/cpuTop.sv
verif/cpuTb.sv

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu (
	input  isaPkg::word_t  operandA,
	input  isaPkg::word_t  operandB,
	input  isaPkg::aluOp_t aluOp,
	output isaPkg::word_t  result,
	output isaPkg::flags_t flags
);
	import isaPkg::*;

	// Signed 4-bit add clamped to -8..7
	function automatic logic [3:0] satNibble(input logic [3:0] x, input logic [3:0] y);
		logic [4:0] sum;
		sum = {x[3], x} + {y[3], y};
		if (sum[4] != sum[3]) begin
			return sum[4] ? 4'h8 : 4'h7;
		end
		return sum[3:0];
	endfunction

	logic [WORD_BITS:0] sum;
	logic [WORD_BITS:0] diff;
	logic [9:0] byteSum;
	logic [2*WORD_BITS-1:0] rotWide;
	logic overflow;

	// One extra sign bit exposes signed overflow
	assign sum = {operandA[WORD_BITS-1], operandA} + {operandB[WORD_BITS-1], operandB};
	assign diff = {operandA[WORD_BITS-1], operandA} - {operandB[WORD_BITS-1], operandB};

	assign byteSum = {{2{operandA[15]}}, operandA[15:8]} + {{2{operandA[7]}}, operandA[7:0]}
		+ {{2{operandB[15]}}, operandB[15:8]} + {{2{operandB[7]}}, operandB[7:0]};

	assign rotWide = {operandA, operandA} >> operandB[3:0];

	always_comb begin
		result = '0;
		overflow = 1'b0;
		case (aluOp)
			ADD: begin
				overflow = sum[WORD_BITS] != sum[WORD_BITS-1];
				result = sum[WORD_BITS-1:0];
				if (overflow) begin
					result = sum[WORD_BITS] ? 16'h8000 : 16'h7FFF;
				end
			end
			SUB: begin
				overflow = diff[WORD_BITS] != diff[WORD_BITS-1];
				result = diff[WORD_BITS-1:0];
				if (overflow) begin
					result = diff[WORD_BITS] ? 16'h8000 : 16'h7FFF;
				end
			end
			RED: result = {{(WORD_BITS-10){byteSum[9]}}, byteSum};
			XOR: result = operandA ^ operandB;
			SLL: result = operandA << operandB[3:0];
			SRA: result = $signed(operandA) >>> operandB[3:0];
			ROR: result = rotWide[WORD_BITS-1:0];
			PADDSB: begin
				for (int i = 0; i < 4; i++) begin
					result[4*i +: 4] = satNibble(operandA[4*i +: 4], operandB[4*i +: 4]);
				end
			end
			default: result = '0;
		endcase
	end

	assign flags[FLAG_Z] = (result == '0);
	assign flags[FLAG_V] = overflow;
	assign flags[FLAG_N] = result[WORD_BITS-1];

endmodule

// ==== source/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
	input  isaPkg::opcode_t opcode,
	output logic            regDst,
	output logic            memRead,
	output logic            memWrite,
	output logic            memToReg,
	output logic            aluSrc,
	output logic            regWrite,
	output logic            loadByte,
	output logic            branch,
	output logic            branchReg,
	output logic            pcSave,
	output logic            halt,
	output isaPkg::aluOp_t  aluOp
);
	import isaPkg::*;

	// regDst high sends rt to read port B, low sends the bits 11:8 register
	always_comb begin
		regDst = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		aluSrc = 1'b0;
		regWrite = 1'b0;
		loadByte = 1'b0;
		branch = 1'b0;
		branchReg = 1'b0;
		pcSave = 1'b0;
		halt = 1'b0;
		aluOp = ADD;
		case (opcode)
			OP_ADD, OP_SUB, OP_RED, OP_XOR, OP_PADDSB: begin
				regDst = 1'b1;
				regWrite = 1'b1;
				aluOp = aluOp_t'(opcode[2:0]);
			end
			// Shift amount comes from the rt field
			OP_SLL, OP_SRA, OP_ROR: begin
				regDst = 1'b1;
				aluSrc = 1'b1;
				regWrite = 1'b1;
				aluOp = aluOp_t'(opcode[2:0]);
			end
			OP_LW: begin
				memRead = 1'b1;
				memToReg = 1'b1;
				aluSrc = 1'b1;
				regWrite = 1'b1;
			end
			OP_SW: begin
				memWrite = 1'b1;
				aluSrc = 1'b1;
			end
			OP_LHB, OP_LLB: begin
				loadByte = 1'b1;
				regWrite = 1'b1;
			end
			OP_B: branch = 1'b1;
			OP_BR: branchReg = 1'b1;
			OP_PCS: begin
				pcSave = 1'b1;
				regWrite = 1'b1;
			end
			OP_HLT: halt = 1'b1;
			default: ;
		endcase
	end

endmodule

// ==== source/cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore (
	input  logic          clk,
	input  logic          reset,
	input  logic          start,
	output logic          halted,
	output logic          fetchReqValid,
	output logic          fetchReqWrite,
	output memPkg::addr_t fetchReqAddr,
	output isaPkg::word_t fetchReqWriteData,
	input  logic          fetchReqReady,
	input  isaPkg::word_t fetchReqReadData,
	output logic          dataReqValid,
	output logic          dataReqWrite,
	output memPkg::addr_t dataReqAddr,
	output isaPkg::word_t dataReqWriteData,
	input  logic          dataReqReady,
	input  isaPkg::word_t dataReqReadData
);
	import isaPkg::*;
	import memPkg::*;

	typedef enum logic [2:0] {IDLE, FETCH, EXECUTE, MEMORY, WRITEBACK, HALTED} state_t;

	state_t state;
	addr_t pc;
	word_t instr;
	word_t resultReg;
	addr_t effAddr;
	flags_t flags;

	opcode_t opcode;
	logic regDst;
	logic memRead;
	logic memWrite;
	logic memToReg;
	logic aluSrc;
	logic regWrite;
	logic loadByte;
	logic branch;
	logic branchReg;
	logic pcSave;
	logic halt;
	aluOp_t aluOp;

	regIndex_t srcB;
	word_t readDataA;
	word_t readDataB;
	word_t aluB;
	word_t aluResult;
	word_t mergedByte;
	word_t execResult;
	flags_t aluFlags;
	logic condTrue;
	logic takeBranch;
	addr_t branchTarget;

	assign opcode = instr[15:12];

	controlUnit decoder (.*);

	assign srcB = regDst ? instr[3:0] : instr[11:8];

	registerFile regFile (
		.clk(clk),
		.reset(reset),
		.readAddrA(instr[7:4]),
		.readAddrB(srcB),
		.writeAddr(instr[11:8]),
		.writeEnable(state == WRITEBACK && regWrite),
		.writeData(resultReg),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	assign aluB = aluSrc ? word_t'(instr[3:0]) : readDataB;

	alu aluUnit (
		.operandA(readDataA),
		.operandB(aluB),
		.aluOp(aluOp),
		.result(aluResult),
		.flags(aluFlags)
	);

	// Port B carries the old rd value for the byte merge
	assign mergedByte = (opcode == OP_LHB) ? {instr[IMM_BITS-1:0], readDataB[7:0]}
		: {readDataB[15:8], instr[IMM_BITS-1:0]};

	// pc already points past the current instruction here
	assign execResult = pcSave ? pc : (loadByte ? mergedByte : aluResult);

	always_comb begin
		case (cond_t'(instr[11:9]))
			COND_NE: condTrue = !flags[FLAG_Z];
			COND_EQ: condTrue = flags[FLAG_Z];
			COND_GT: condTrue = !flags[FLAG_Z] && !flags[FLAG_N];
			COND_LT: condTrue = flags[FLAG_N];
			COND_GE: condTrue = flags[FLAG_Z] || !flags[FLAG_N];
			COND_LE: condTrue = flags[FLAG_Z] || flags[FLAG_N];
			COND_OV: condTrue = flags[FLAG_V];
			default: condTrue = 1'b1;
		endcase
	end

	assign takeBranch = (branch || branchReg) && condTrue;
	assign branchTarget = branchReg ? readDataA
		: pc + {{(WORD_BITS-BRANCH_OFFSET_BITS){instr[BRANCH_OFFSET_BITS-1]}},
			instr[BRANCH_OFFSET_BITS-1:0]};

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			pc <= '0;
			flags <= '0;
		end else begin
			case (state)
				IDLE: if (start) state <= FETCH;
				FETCH: begin
					if (fetchReqReady) begin
						pc <= pc + 1'b1;
						state <= EXECUTE;
					end
				end
				EXECUTE: begin
					if (halt) state <= HALTED;
					else if (memRead || memWrite) state <= MEMORY;
					else state <= WRITEBACK;
					if (takeBranch) pc <= branchTarget;
					if (opcode inside {OP_ADD, OP_SUB}) begin
						flags <= aluFlags;
					end else if (opcode inside {OP_XOR, OP_SLL, OP_SRA, OP_ROR}) begin
						flags[FLAG_Z] <= aluFlags[FLAG_Z];
					end
				end
				MEMORY: if (dataReqReady) state <= WRITEBACK;
				WRITEBACK: state <= FETCH;
				default: state <= HALTED;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == FETCH && fetchReqReady) instr <= fetchReqReadData;
		if (state == EXECUTE) begin
			resultReg <= execResult;
			effAddr <= readDataA + {{(WORD_BITS-MEM_OFFSET_BITS){instr[MEM_OFFSET_BITS-1]}},
				instr[MEM_OFFSET_BITS-1:0]};
		end
		if (state == MEMORY && dataReqReady && memToReg) resultReg <= dataReqReadData;
	end

	assign fetchReqValid = (state == FETCH);
	assign fetchReqWrite = 1'b0;
	assign fetchReqAddr = pc;
	assign fetchReqWriteData = '0;

	assign dataReqValid = (state == MEMORY);
	assign dataReqWrite = memWrite;
	assign dataReqAddr = effAddr;
	assign dataReqWriteData = readDataB;

	assign halted = (state == HALTED);

endmodule

// ==== source/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop (
	input  logic          clk,
	input  logic          reset,
	input  logic          start,
	output logic          halted,
	input  logic          hostValid,
	input  logic          hostWrite,
	input  memPkg::addr_t hostAddr,
	input  isaPkg::word_t hostWriteData,
	output logic          hostReady,
	output isaPkg::word_t hostReadData
);
	import isaPkg::*;
	import memPkg::*;

	logic fetchReqValid;
	logic fetchReqWrite;
	logic fetchReqReady;
	addr_t fetchReqAddr;
	word_t fetchReqWriteData;
	word_t fetchReqReadData;

	logic dataReqValid;
	logic dataReqWrite;
	logic dataReqReady;
	addr_t dataReqAddr;
	word_t dataReqWriteData;
	word_t dataReqReadData;

	logic memValid;
	logic memWrite;
	logic memReady;
	addr_t memAddr;
	word_t memWriteData;
	word_t memReadData;

	cpuCore core (.*);

	memArbiter arbiter (
		.hostReqValid(hostValid),
		.hostReqWrite(hostWrite),
		.hostReqAddr(hostAddr),
		.hostReqWriteData(hostWriteData),
		.hostReqReady(hostReady),
		.hostReqReadData(hostReadData),
		.*
	);

	unifiedMemory memory (.*);

endmodule

// ==== source/isaPkg.sv ====
package isaPkg;

	localparam int WORD_BITS = 16;
	localparam int OPCODE_BITS = 4;
	localparam int REG_FIELD_BITS = 4;
	localparam int MEM_OFFSET_BITS = 4;
	localparam int IMM_BITS = 8;
	localparam int COND_BITS = 3;
	localparam int BRANCH_OFFSET_BITS = 9;

	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [OPCODE_BITS-1:0] opcode_t;
	typedef logic [REG_FIELD_BITS-1:0] regIndex_t;
	typedef logic [2:0] flags_t;
	typedef logic [COND_BITS-1:0] cond_t;

	// Bit positions inside flags_t
	localparam int FLAG_Z = 2;
	localparam int FLAG_V = 1;
	localparam int FLAG_N = 0;

	// Encodings follow the low three opcode bits of the arithmetic group
	typedef enum logic [2:0] {
		ADD    = 3'd0,
		SUB    = 3'd1,
		RED    = 3'd2,
		XOR    = 3'd3,
		SLL    = 3'd4,
		SRA    = 3'd5,
		ROR    = 3'd6,
		PADDSB = 3'd7
	} aluOp_t;

	// Layout is opcode[15:12] rd[11:8] rs[7:4] rt[3:0]
	// LW/SW hold the data register in bits 11:8 and a signed word offset in 3:0
	// LHB/LLB hold rd and imm[7:0], B holds cond[11:9] and offset[8:0]
	localparam opcode_t OP_ADD    = 4'h0;
	localparam opcode_t OP_SUB    = 4'h1;
	localparam opcode_t OP_RED    = 4'h2;
	localparam opcode_t OP_XOR    = 4'h3;
	localparam opcode_t OP_SLL    = 4'h4;
	localparam opcode_t OP_SRA    = 4'h5;
	localparam opcode_t OP_ROR    = 4'h6;
	localparam opcode_t OP_PADDSB = 4'h7;
	localparam opcode_t OP_LW     = 4'h8;
	localparam opcode_t OP_SW     = 4'h9;
	localparam opcode_t OP_LHB    = 4'hA;
	localparam opcode_t OP_LLB    = 4'hB;
	localparam opcode_t OP_B      = 4'hC;
	localparam opcode_t OP_BR     = 4'hD;
	localparam opcode_t OP_PCS    = 4'hE;
	localparam opcode_t OP_HLT    = 4'hF;

	localparam cond_t COND_NE     = 3'b000;
	localparam cond_t COND_EQ     = 3'b001;
	localparam cond_t COND_GT     = 3'b010;
	localparam cond_t COND_LT     = 3'b011;
	localparam cond_t COND_GE     = 3'b100;
	localparam cond_t COND_LE     = 3'b101;
	localparam cond_t COND_OV     = 3'b110;
	localparam cond_t COND_ALWAYS = 3'b111;

endpackage

// ==== source/memArbiter.sv ====
`timescale 1ns/1ps

module memArbiter (
	input  logic          clk,
	input  logic          reset,
	input  logic          dataReqValid,
	input  logic          dataReqWrite,
	input  memPkg::addr_t dataReqAddr,
	input  isaPkg::word_t dataReqWriteData,
	output logic          dataReqReady,
	output isaPkg::word_t dataReqReadData,
	input  logic          fetchReqValid,
	input  logic          fetchReqWrite,
	input  memPkg::addr_t fetchReqAddr,
	input  isaPkg::word_t fetchReqWriteData,
	output logic          fetchReqReady,
	output isaPkg::word_t fetchReqReadData,
	input  logic          hostReqValid,
	input  logic          hostReqWrite,
	input  memPkg::addr_t hostReqAddr,
	input  isaPkg::word_t hostReqWriteData,
	output logic          hostReqReady,
	output isaPkg::word_t hostReqReadData,
	output logic          memValid,
	output logic          memWrite,
	output memPkg::addr_t memAddr,
	output isaPkg::word_t memWriteData,
	input  logic          memReady,
	input  isaPkg::word_t memReadData
);
	import isaPkg::*;
	import memPkg::*;

	// Index 0 has the highest priority
	logic [REQUESTERS-1:0] reqValid;
	logic [REQUESTERS-1:0] reqWrite;
	addr_t reqAddr [REQUESTERS];
	word_t reqWriteData [REQUESTERS];
	logic [REQUESTERS-1:0] pick;
	logic [REQUESTERS-1:0] owner;
	logic [REQUESTERS-1:0] grant;
	logic locked;

	assign reqValid = {hostReqValid, fetchReqValid, dataReqValid};
	assign reqWrite = {hostReqWrite, fetchReqWrite, dataReqWrite};
	assign reqAddr = '{dataReqAddr, fetchReqAddr, hostReqAddr};
	assign reqWriteData = '{dataReqWriteData, fetchReqWriteData, hostReqWriteData};

	// Lowest set bit of the valid vector
	assign pick = reqValid & (~reqValid + 1'b1);
	assign grant = locked ? owner : pick;

	always_comb begin
		memWrite = 1'b0;
		memAddr = '0;
		memWriteData = '0;
		for (int i = 0; i < REQUESTERS; i++) begin
			if (grant[i]) begin
				memWrite = reqWrite[i];
				memAddr = reqAddr[i];
				memWriteData = reqWriteData[i];
			end
		end
	end

	assign memValid = |(grant & reqValid);

	// Hold the owner from acceptance through the ready cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			locked <= 1'b0;
			owner <= '0;
		end else if (!locked && |reqValid) begin
			locked <= 1'b1;
			owner <= pick;
		end else if (locked && memReady) begin
			locked <= 1'b0;
		end
	end

	assign dataReqReady = grant[0] & memReady;
	assign fetchReqReady = grant[1] & memReady;
	assign hostReqReady = grant[2] & memReady;

	assign dataReqReadData = memReadData;
	assign fetchReqReadData = memReadData;
	assign hostReqReadData = memReadData;

endmodule

// ==== source/memPkg.sv ====
package memPkg;

	localparam int ADDR_BITS = 16;
	localparam int MEM_DEPTH = 256;
	localparam int MEM_INDEX_BITS = $clog2(MEM_DEPTH);

	// Data, fetch and host
	localparam int REQUESTERS = 3;

	typedef logic [ADDR_BITS-1:0] addr_t;

endpackage

// ==== source/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
	input  logic              clk,
	input  logic              reset,
	input  isaPkg::regIndex_t readAddrA,
	input  isaPkg::regIndex_t readAddrB,
	input  isaPkg::regIndex_t writeAddr,
	input  logic              writeEnable,
	input  isaPkg::word_t     writeData,
	output isaPkg::word_t     readDataA,
	output isaPkg::word_t     readDataB
);
	import isaPkg::*;

	word_t regs [2**REG_FIELD_BITS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**REG_FIELD_BITS; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Register 0 is hardwired to zero
	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// ==== source/unifiedMemory.sv ====
`timescale 1ns/1ps

module unifiedMemory (
	input  logic          clk,
	input  logic          reset,
	input  logic          memValid,
	input  logic          memWrite,
	input  memPkg::addr_t memAddr,
	input  isaPkg::word_t memWriteData,
	output logic          memReady,
	output isaPkg::word_t memReadData
);
	import isaPkg::*;
	import memPkg::*;

	word_t mem [MEM_DEPTH];
	logic [MEM_INDEX_BITS-1:0] index;
	logic accept;

	assign index = memAddr[MEM_INDEX_BITS-1:0];

	// No new request is taken in the ready cycle
	assign accept = memValid && !memReady;

	always_ff @(posedge clk) begin
		if (reset) begin
			memReady <= 1'b0;
		end else begin
			memReady <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			if (memWrite) begin
				mem[index] <= memWriteData;
			end
			memReadData <= mem[index];
		end
	end

endmodule

// ==== verif/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;
	import isaPkg::*;
	import memPkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int CYCLES_PER_WORD = 20;
	localparam int HOST_ACCESS_CYCLES = 4;
	localparam int ARITH_BASE = 8'h80;
	localparam int SHIFT_BASE = 8'hA0;
	localparam int BRANCH_BASE = 8'hD0;
	localparam int MISC_BASE = 8'hF0;
	localparam word_t SENTINEL = 16'hDEAD;
	localparam word_t MARKER = 16'h5A5A;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic start;
	logic halted;
	logic hostValid;
	logic hostWrite;
	addr_t hostAddr;
	word_t hostWriteData;
	logic hostReady;
	word_t hostReadData;

	word_t prog [$];
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int cycleLimit = RESET_CYCLES + 20;
	logic [31:0] rngState = 32'd46;

	cpuTop UUT (.*);

	always #10 clk = ~clk;

	// Watchdog, the limit grows as each test queues its work
	initial begin
		while (cycles < cycleLimit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: no progress after %0d cycles", cycles);
		$display("Checks failed");
		$finish;
	end

	function automatic word_t xorshiftNext();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState[15:0];
	endfunction

	function automatic word_t regOp(opcode_t op, regIndex_t rd, regIndex_t rs, regIndex_t rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic word_t memOp(opcode_t op, regIndex_t dataReg, regIndex_t base, int offset);
		return {op, dataReg, base, 4'(offset)};
	endfunction

	function automatic word_t byteOp(opcode_t op, regIndex_t rd, logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic word_t condBranch(cond_t c, int offset);
		return {OP_B, c, 9'(offset)};
	endfunction

	function automatic word_t regBranch(cond_t c, regIndex_t rs);
		return {OP_BR, c, 1'b0, rs, 4'h0};
	endfunction

	function automatic word_t haltWord();
		return {OP_HLT, 12'h000};
	endfunction

	function automatic word_t clampWord(int s);
		if (s > 32767) return 16'h7FFF;
		if (s < -32768) return 16'h8000;
		return word_t'(s);
	endfunction

	function automatic word_t satAdd(word_t a, word_t b);
		return clampWord(int'($signed(a)) + int'($signed(b)));
	endfunction

	function automatic word_t satSub(word_t a, word_t b);
		return clampWord(int'($signed(a)) - int'($signed(b)));
	endfunction

	function automatic word_t byteReduce(word_t a, word_t b);
		int s;
		s = int'($signed(a[15:8])) + int'($signed(a[7:0]))
			+ int'($signed(b[15:8])) + int'($signed(b[7:0]));
		return word_t'(s);
	endfunction

	function automatic word_t nibbleAddSat(word_t a, word_t b);
		word_t r;
		int s;
		for (int i = 0; i < 4; i++) begin
			s = int'($signed(a[4*i +: 4])) + int'($signed(b[4*i +: 4]));
			if (s > 7) s = 7;
			if (s < -8) s = -8;
			r[4*i +: 4] = 4'(s);
		end
		return r;
	endfunction

	function automatic word_t shiftLeft(word_t a, int n);
		word_t r;
		r = a;
		for (int i = 0; i < n; i++) r = {r[14:0], 1'b0};
		return r;
	endfunction

	function automatic word_t arithShiftRight(word_t a, int n);
		word_t r;
		r = a;
		for (int i = 0; i < n; i++) r = {r[15], r[15:1]};
		return r;
	endfunction

	function automatic word_t rotateRight(word_t a, int n);
		word_t r;
		r = a;
		for (int i = 0; i < n; i++) r = {r[0], r[15:1]};
		return r;
	endfunction

	function automatic logic condHolds(int c, logic z, logic v, logic n);
		case (c)
			0: return !z;
			1: return z;
			2: return !z && !n;
			3: return n;
			4: return !n;
			5: return z || n;
			6: return v;
			default: return 1'b1;
		endcase
	endfunction

	task automatic compareWord(input string what, input word_t got, input word_t expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("Fail at time %0t: %s read %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic applyReset();
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	task automatic writeWord(input addr_t addr, input word_t data);
		cycleLimit += HOST_ACCESS_CYCLES;
		@(posedge clk);
		#1;
		hostValid = 1'b1;
		hostWrite = 1'b1;
		hostAddr = addr;
		hostWriteData = data;
		@(negedge clk);
		while (!hostReady) @(negedge clk);
		@(posedge clk);
		#1;
		hostValid = 1'b0;
		hostWrite = 1'b0;
	endtask

	task automatic readWord(input addr_t addr, output word_t data);
		cycleLimit += HOST_ACCESS_CYCLES;
		@(posedge clk);
		#1;
		hostValid = 1'b1;
		hostWrite = 1'b0;
		hostAddr = addr;
		@(negedge clk);
		while (!hostReady) @(negedge clk);
		data = hostReadData;
		@(posedge clk);
		#1;
		hostValid = 1'b0;
	endtask

	// LLB then LHB sets all sixteen bits
	task automatic emitConst(input regIndex_t rd, input word_t value);
		prog.push_back(byteOp(OP_LLB, rd, value[7:0]));
		prog.push_back(byteOp(OP_LHB, rd, value[15:8]));
	endtask

	task automatic runProgram();
		cycleLimit += RESET_CYCLES + CYCLES_PER_WORD * prog.size();
		applyReset();
		for (int i = 0; i < prog.size(); i++) writeWord(addr_t'(i), prog[i]);
		@(posedge clk);
		#1;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		while (!halted) @(negedge clk);
	endtask

	task automatic hostAccessTest();
		addr_t addrs [8];
		word_t data [8];
		word_t got;
		for (int i = 0; i < 8; i++) begin
			addrs[i] = addr_t'(8'(i * 29 + 7));
			data[i] = xorshiftNext();
			writeWord(addrs[i], data[i]);
		end
		for (int i = 0; i < 8; i++) begin
			readWord(addrs[i], got);
			compareWord($sformatf("host word at %h", addrs[i]), got, data[i]);
		end
	endtask

	task automatic arithmeticTest();
		word_t opA [4];
		word_t opB [4];
		word_t expected [5];
		word_t got;
		opA[0] = xorshiftNext();
		opB[0] = xorshiftNext();
		opA[1] = xorshiftNext();
		opB[1] = xorshiftNext();
		// SUB saturates high, then ADD saturates low
		opA[2] = 16'h7FFF;
		opB[2] = 16'hF000;
		opA[3] = 16'h8005;
		opB[3] = 16'h9000;
		prog.delete();
		for (int p = 0; p < 4; p++) begin
			emitConst(1, opA[p]);
			emitConst(2, opB[p]);
			prog.push_back(regOp(OP_ADD, 3, 1, 2));
			prog.push_back(regOp(OP_SUB, 4, 1, 2));
			prog.push_back(regOp(OP_XOR, 5, 1, 2));
			prog.push_back(regOp(OP_RED, 6, 1, 2));
			prog.push_back(regOp(OP_PADDSB, 7, 1, 2));
			prog.push_back(byteOp(OP_LLB, 15, 8'(ARITH_BASE + 5 * p)));
			for (int k = 0; k < 5; k++) prog.push_back(memOp(OP_SW, regIndex_t'(3 + k), 15, k));
		end
		prog.push_back(haltWord());
		runProgram();
		for (int p = 0; p < 4; p++) begin
			expected[0] = satAdd(opA[p], opB[p]);
			expected[1] = satSub(opA[p], opB[p]);
			expected[2] = opA[p] ^ opB[p];
			expected[3] = byteReduce(opA[p], opB[p]);
			expected[4] = nibbleAddSat(opA[p], opB[p]);
			for (int k = 0; k < 5; k++) begin
				readWord(addr_t'(ARITH_BASE + 5 * p + k), got);
				compareWord($sformatf("pair %0d result %0d", p, k), got, expected[k]);
			end
		end
	endtask

	task automatic shiftTest();
		word_t value;
		word_t got;
		// Sign bit set so SRA fills with ones
		value = xorshiftNext() | 16'h8000;
		prog.delete();
		emitConst(1, value);
		for (int n = 0; n < 16; n++) begin
			prog.push_back(regOp(OP_SLL, 2, 1, regIndex_t'(n)));
			prog.push_back(regOp(OP_SRA, 3, 1, regIndex_t'(n)));
			prog.push_back(regOp(OP_ROR, 4, 1, regIndex_t'(n)));
			prog.push_back(byteOp(OP_LLB, 15, 8'(SHIFT_BASE + 3 * n)));
			for (int k = 0; k < 3; k++) prog.push_back(memOp(OP_SW, regIndex_t'(2 + k), 15, k));
		end
		prog.push_back(haltWord());
		runProgram();
		for (int n = 0; n < 16; n++) begin
			readWord(addr_t'(SHIFT_BASE + 3 * n), got);
			compareWord($sformatf("SLL by %0d", n), got, shiftLeft(value, n));
			readWord(addr_t'(SHIFT_BASE + 3 * n + 1), got);
			compareWord($sformatf("SRA by %0d", n), got, arithShiftRight(value, n));
			readWord(addr_t'(SHIFT_BASE + 3 * n + 2), got);
			compareWord($sformatf("ROR by %0d", n), got, rotateRight(value, n));
		end
	endtask

	// Each taken branch skips the marker store right after it
	task automatic branchTest();
		regIndex_t srcA [4];
		regIndex_t srcB [4];
		word_t regVal [8];
		word_t diff;
		word_t got;
		int wide;
		logic z;
		logic v;
		logic n;
		srcA = '{1, 1, 2, 3};
		srcB = '{2, 1, 1, 4};
		regVal[1] = 16'd5;
		regVal[2] = 16'd9;
		regVal[3] = 16'h8000;
		regVal[4] = 16'd1;
		for (int i = 0; i < 32; i++) writeWord(addr_t'(BRANCH_BASE + i), SENTINEL);
		prog.delete();
		prog.push_back(byteOp(OP_LLB, 1, 8'd5));
		prog.push_back(byteOp(OP_LLB, 2, 8'd9));
		prog.push_back(byteOp(OP_LHB, 3, 8'h80));
		prog.push_back(byteOp(OP_LLB, 4, 8'd1));
		emitConst(6, MARKER);
		for (int s = 0; s < 4; s++) begin
			prog.push_back(byteOp(OP_LLB, 15, 8'(BRANCH_BASE + 8 * s)));
			prog.push_back(regOp(OP_SUB, 7, srcA[s], srcB[s]));
			for (int c = 0; c < 8; c++) begin
				if (s == 2) begin
					// Target lies past the LLB, the BR and the store
					prog.push_back(byteOp(OP_LLB, 5, 8'(prog.size() + 3)));
					prog.push_back(regBranch(cond_t'(c), 5));
				end else begin
					prog.push_back(condBranch(cond_t'(c), 1));
				end
				prog.push_back(memOp(OP_SW, 6, 15, c));
			end
		end
		prog.push_back(haltWord());
		runProgram();
		for (int s = 0; s < 4; s++) begin
			wide = int'($signed(regVal[srcA[s]])) - int'($signed(regVal[srcB[s]]));
			diff = satSub(regVal[srcA[s]], regVal[srcB[s]]);
			z = (diff == 16'h0000);
			v = (wide > 32767) || (wide < -32768);
			n = diff[15];
			for (int c = 0; c < 8; c++) begin
				readWord(addr_t'(BRANCH_BASE + 8 * s + c), got);
				compareWord($sformatf("case %0d condition %0d marker", s, c), got,
					condHolds(c, z, v, n) ? SENTINEL : MARKER);
			end
		end
	endtask

	task automatic pcsHaltTest();
		word_t expected [5];
		word_t got;
		int firstPcs;
		int secondPcs;
		for (int i = 0; i < 5; i++) writeWord(addr_t'(MISC_BASE + i), SENTINEL);
		prog.delete();
		firstPcs = prog.size();
		prog.push_back(byteOp(OP_PCS, 1, 8'h00));
		prog.push_back(byteOp(OP_LLB, 15, 8'(MISC_BASE)));
		prog.push_back(memOp(OP_SW, 1, 15, 0));
		prog.push_back(byteOp(OP_LLB, 2, 8'h77));
		prog.push_back(regOp(OP_ADD, 0, 2, 2));
		prog.push_back(memOp(OP_SW, 0, 15, 1));
		secondPcs = prog.size();
		prog.push_back(byteOp(OP_PCS, 3, 8'h00));
		prog.push_back(memOp(OP_SW, 3, 15, 2));
		prog.push_back(memOp(OP_LW, 4, 15, 0));
		prog.push_back(memOp(OP_SW, 4, 15, 3));
		prog.push_back(haltWord());
		// Never reached
		prog.push_back(memOp(OP_SW, 2, 15, 4));
		runProgram();
		repeat (10) @(negedge clk);
		checks++;
		if (halted !== 1'b1) begin
			errors++;
			$display("Fail at time %0t: halted dropped after HLT", $time);
		end
		expected[0] = word_t'(firstPcs + 1);
		expected[1] = 16'h0000;
		expected[2] = word_t'(secondPcs + 1);
		expected[3] = word_t'(firstPcs + 1);
		expected[4] = SENTINEL;
		for (int k = 0; k < 5; k++) begin
			readWord(addr_t'(MISC_BASE + k), got);
			compareWord($sformatf("misc slot %0d", k), got, expected[k]);
		end
	endtask

	initial begin
		start = 1'b0;
		hostValid = 1'b0;
		hostWrite = 1'b0;
		hostAddr = '0;
		hostWriteData = '0;
		applyReset();
		hostAccessTest();
		arithmeticTest();
		shiftTest();
		branchTest();
		pcsHaltTest();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
